// File: common/qla_pkg.sv
`default_nettype none

package qla_pkg;

    // ---------------------------------------------------------------------
    // register map
    localparam int unsigned NUM_AXES = 4;

    typedef logic [15:0] reg_addr_t;   // [15:12] space, [7:4] channel, [3:0] offset
    typedef logic [31:0] reg_data_t;

    localparam logic [3:0] ADDR_MAIN        = 4'h0;
    localparam logic [3:0] CHAN_BOARD       = 4'h0;   // board channel, axes are 1..4
    localparam logic [3:0] OFF_BOARD_STATUS = 4'h0;
    localparam logic [3:0] OFF_DAC_CTRL     = 4'h1;
    localparam int unsigned PWR_CLEAR_BIT   = 8;      // clears every axis latch

    // currents, one word per axis
    typedef logic [15:0] cur_t;
    typedef cur_t [NUM_AXES-1:0] axis_cur_t;          // axis 4 in the top word
    typedef logic [NUM_AXES-1:0] axis_mask_t;

    // ---------------------------------------------------------------------
    // dac spi framing
    localparam int unsigned DAC_BITS   = 16;
    localparam int unsigned FRAME_BITS = NUM_AXES * DAC_BITS;
    localparam int unsigned SCLK_HALF  = 2;           // sysclk cycles per half sclk
    localparam int unsigned CSEL_GAP   = 4;           // min csel high time

    localparam int unsigned SCLK_CNT_W = $clog2(SCLK_HALF + 1);
    localparam int unsigned BIT_CNT_W  = $clog2(FRAME_BITS);
    localparam int unsigned GAP_CNT_W  = $clog2(CSEL_GAP);

    localparam logic [SCLK_CNT_W-1:0] SCLK_CNT_LAST = SCLK_CNT_W'(SCLK_HALF - 1);
    localparam logic [BIT_CNT_W-1:0]  BIT_CNT_LAST  = BIT_CNT_W'(FRAME_BITS - 1);
    localparam logic [GAP_CNT_W-1:0]  GAP_CNT_LAST  = GAP_CNT_W'(CSEL_GAP - 1);

    // ---------------------------------------------------------------------
    // over-current trip
    localparam int unsigned SAFETY_COUNT = 16;        // consecutive cycles to trip
    localparam int unsigned SAFETY_CNT_W = $clog2(SAFETY_COUNT);
    localparam logic [SAFETY_CNT_W-1:0] SAFETY_CNT_LAST = SAFETY_CNT_W'(SAFETY_COUNT - 1);

endpackage

`default_nettype wire

// File: common/dac_step_if.sv
`default_nettype none

// bit-level handshake of one dac frame
interface dac_step_if;

    logic run;     // frame in progress, from the sequencer
    logic sclk;    // spi clock, idles low
    logic shift;   // strobe, sclk falls at the end of this cycle
    logic last;    // one cycle after the rising edge of the final bit

    modport seq (output run, input last);
    modport timer (input run, output sclk, output shift, output last);
    modport shifter (input shift, input last);

endinterface

`default_nettype wire

// File: src/board_regs.sv
`default_nettype none

module board_regs (
    input  wire                     sysclk,
    input  wire                     rst_n,
    input  wire                     reg_wen,
    input  wire qla_pkg::reg_addr_t reg_waddr,
    input  wire qla_pkg::reg_data_t reg_wdata,
    input  wire qla_pkg::reg_addr_t reg_raddr,
    input  wire                     frame_taken,   // sequencer grabbed cmd
    input  wire qla_pkg::axis_mask_t amp_disable,
    output qla_pkg::reg_data_t      reg_rdata,
    output qla_pkg::axis_cur_t      cmd,
    output logic                    dac_pending,
    output qla_pkg::axis_mask_t     amp_clear
);

    // ---------------------------------------------------------------------
    // write decode
    logic                wr_main;     // main space, bits 11..8 clear
    logic                wr_status;   // board status write
    qla_pkg::axis_mask_t wr_axis;     // dac command write, per axis
    qla_pkg::axis_mask_t amp_en;      // amp enable register
    logic                rd_main;

    assign wr_main = reg_wen && (reg_waddr[15:12] == qla_pkg::ADDR_MAIN)
                     && (reg_waddr[11:8] == 4'h0);
    assign wr_status = wr_main && (reg_waddr[7:4] == qla_pkg::CHAN_BOARD)
                       && (reg_waddr[3:0] == qla_pkg::OFF_BOARD_STATUS);

    always_comb begin
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            // channel n holds axis n-1
            wr_axis[i] = wr_main && (reg_waddr[7:4] == 4'(i + 1))
                         && (reg_waddr[3:0] == qla_pkg::OFF_DAC_CTRL);
        end
    end

    // axis current commands
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            cmd <= '0;
        end else begin
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                if (wr_axis[i])
                    cmd[i] <= reg_wdata[15:0];
            end
        end
    end

    // pending until the sequencer takes it, a write on the take cycle wins
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            dac_pending <= 1'b0;
        else if (|wr_axis)
            dac_pending <= 1'b1;
        else if (frame_taken)
            dac_pending <= 1'b0;
    end

    // amp enables and the one-cycle clear pulses
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            amp_en    <= '0;
            amp_clear <= '0;
        end else begin
            amp_clear <= '0;
            if (wr_status) begin
                amp_en    <= reg_wdata[3:0];
                amp_clear <= reg_wdata[3:0]
                             | {qla_pkg::NUM_AXES{reg_wdata[qla_pkg::PWR_CLEAR_BIT]}};
            end
        end
    end

    // ---------------------------------------------------------------------
    // read mux, unmapped reads give 0
    assign rd_main = (reg_raddr[15:12] == qla_pkg::ADDR_MAIN) && (reg_raddr[11:8] == 4'h0);

    always_comb begin
        reg_rdata = '0;
        if (rd_main) begin
            if (reg_raddr[7:4] == qla_pkg::CHAN_BOARD
                && reg_raddr[3:0] == qla_pkg::OFF_BOARD_STATUS) begin
                reg_rdata[3:0]  = amp_en;
                reg_rdata[11:8] = amp_disable;   // latched trips
            end
            for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
                if (reg_raddr[7:4] == 4'(i + 1) && reg_raddr[3:0] == qla_pkg::OFF_DAC_CTRL)
                    reg_rdata[15:0] = cmd[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: src/safety_check.sv
`default_nettype none

// trips when feedback stays above twice the command for SAFETY_COUNT cycles
module safety_check (
    input  wire                sysclk,
    input  wire                rst_n,
    input  wire qla_pkg::cur_t cur_in,          // feedback magnitude
    input  wire qla_pkg::cur_t cmd_in,          // commanded magnitude
    input  wire                clear_disable,   // pulse from status write
    output logic               amp_disable
);

    // ---------------------------------------------------------------------
    // compare in one extra bit so 2*cmd cannot wrap
    logic [$bits(qla_pkg::cur_t):0] fb_ext;
    logic [$bits(qla_pkg::cur_t):0] cmd_x2;
    logic                           excess;
    logic [qla_pkg::SAFETY_CNT_W-1:0] over_cnt;   // consecutive excess cycles

    assign fb_ext = {1'b0, cur_in};
    assign cmd_x2 = {cmd_in, 1'b0};
    assign excess = fb_ext > cmd_x2;

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            over_cnt    <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            over_cnt    <= '0;   // restart persistence window
            amp_disable <= 1'b0;
        end else if (excess) begin
            if (over_cnt == qla_pkg::SAFETY_CNT_LAST)
                amp_disable <= 1'b1;   // latch until cleared
            else
                over_cnt <= over_cnt + 1'b1;
        end else begin
            over_cnt <= '0;   // streak broken
        end
    end

endmodule

`default_nettype wire

// File: dac/dac_seq_fsm.sv
`default_nettype none

// starts one frame per pending update and holds csel high between frames
module dac_seq_fsm (
    input  wire                     sysclk,
    input  wire                     rst_n,
    input  wire                     dac_pending,
    input  wire qla_pkg::axis_cur_t cmd,
    dac_step_if.seq                 step,
    output logic                    frame_taken,
    output logic                    load,
    output logic [qla_pkg::FRAME_BITS-1:0] frame,
    output logic                    dac_csel
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,    // frame sampled, shifter loads now
        ST_SHIFT,   // csel low, timer running
        ST_GAP      // csel high spacing
    } seq_state_t;

    seq_state_t                    state;
    logic [qla_pkg::GAP_CNT_W-1:0] gap_cnt;

    // ---------------------------------------------------------------------
    // take happens in idle, same cycle clears the pending flag
    assign frame_taken = (state == ST_IDLE) && dac_pending;
    assign load        = (state == ST_LOAD);
    assign step.run    = (state == ST_SHIFT);

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            gap_cnt  <= '0;
            dac_csel <= 1'b1;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (frame_taken)
                        state <= ST_LOAD;
                end
                ST_LOAD: begin
                    state    <= ST_SHIFT;
                    dac_csel <= 1'b0;   // low two cycles after the write
                end
                ST_SHIFT: begin
                    if (step.last) begin
                        state    <= ST_GAP;
                        dac_csel <= 1'b1;   // one cycle after the last rise
                        gap_cnt  <= '0;
                    end
                end
                ST_GAP: begin
                    if (gap_cnt == qla_pkg::GAP_CNT_LAST)
                        state <= ST_IDLE;
                    else
                        gap_cnt <= gap_cnt + 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // snapshot of all four commands, axis 4 lands in the top bits
    always_ff @(posedge sysclk) begin
        if (frame_taken)
            frame <= cmd;
    end

endmodule

`default_nettype wire

// File: dac/spi_bit_timer.sv
`default_nettype none

// sclk generator and bit counter for one frame
module spi_bit_timer (
    input  wire       sysclk,
    input  wire       rst_n,
    dac_step_if.timer step
);

    logic [qla_pkg::SCLK_CNT_W-1:0] half_cnt;   // cycles into this half period
    logic [qla_pkg::BIT_CNT_W-1:0]  bit_cnt;    // rising edges so far
    logic                           half_done;
    logic                           rise_next;  // sclk goes high at the coming edge

    assign half_done  = (half_cnt == qla_pkg::SCLK_CNT_LAST);
    assign rise_next  = step.run && half_done && !step.sclk;
    assign step.shift = step.run && half_done && step.sclk;   // falling edge

    // ---------------------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            half_cnt  <= '0;
            bit_cnt   <= '0;
            step.sclk <= 1'b0;
            step.last <= 1'b0;
        end else if (!step.run) begin
            half_cnt  <= '0;   // idle, sclk parked low
            bit_cnt   <= '0;
            step.sclk <= 1'b0;
            step.last <= 1'b0;
        end else begin
            step.last <= rise_next && (bit_cnt == qla_pkg::BIT_CNT_LAST);
            if (half_done) begin
                half_cnt  <= '0;
                step.sclk <= !step.sclk;
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
            if (rise_next)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: dac/dac_shifter.sv
`default_nettype none

// msb-first frame shift register for the dac chain
module dac_shifter (
    input  wire                            sysclk,
    input  wire                            rst_n,
    input  wire                            load,    // from sequencer
    input  wire [qla_pkg::FRAME_BITS-1:0]  frame,
    dac_step_if.shifter                    step,
    output logic                           mosi
);

    logic [qla_pkg::FRAME_BITS-1:0] shreg;

    // ---------------------------------------------------------------------
    // data moves on the falling sclk edge, stable for the next rise
    always_ff @(posedge sysclk) begin
        if (!rst_n)
            shreg <= '0;
        else if (load)
            shreg <= frame;
        else if (step.last)
            shreg <= '0;   // frame out, drop the line
        else if (step.shift)
            shreg <= {shreg[qla_pkg::FRAME_BITS-2:0], 1'b0};
    end

    assign mosi = shreg[qla_pkg::FRAME_BITS-1];

endmodule

`default_nettype wire

// File: src/qla_motor_top.sv
`default_nettype none

module qla_motor_top (
    input  wire                      sysclk,
    input  wire                      rst_n,
    // host register bus
    input  wire                      reg_wen,
    input  wire qla_pkg::reg_addr_t  reg_waddr,
    input  wire qla_pkg::reg_addr_t  reg_raddr,
    input  wire qla_pkg::reg_data_t  reg_wdata,
    output qla_pkg::reg_data_t       reg_rdata,
    // adc feedback, one word per axis
    input  wire qla_pkg::axis_cur_t  cur_fb,
    // dac spi chain
    output logic                     dac_sclk,
    output logic                     dac_mosi,
    output logic                     dac_csel,
    output qla_pkg::axis_mask_t      amp_disable
);

    qla_pkg::axis_cur_t  cmd;           // current commands
    qla_pkg::axis_mask_t amp_clear;
    logic                dac_pending;
    logic                frame_taken;
    logic                load;
    logic [qla_pkg::FRAME_BITS-1:0] frame;

    dac_step_if step ();

    // ---------------------------------------------------------------------
    // register file
    board_regs u_regs (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .reg_raddr   (reg_raddr),
        .frame_taken (frame_taken),
        .amp_disable (amp_disable),
        .reg_rdata   (reg_rdata),
        .cmd         (cmd),
        .dac_pending (dac_pending),
        .amp_clear   (amp_clear)
    );

    // ---------------------------------------------------------------------
    // dac chain
    dac_seq_fsm u_dac_seq (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .dac_pending (dac_pending),
        .cmd         (cmd),
        .step        (step.seq),
        .frame_taken (frame_taken),
        .load        (load),
        .frame       (frame),
        .dac_csel    (dac_csel)
    );

    spi_bit_timer u_bit_timer (.sysclk(sysclk), .rst_n(rst_n), .step(step.timer));

    dac_shifter u_shifter (
        .sysclk (sysclk),
        .rst_n  (rst_n),
        .load   (load),
        .frame  (frame),
        .step   (step.shifter),
        .mosi   (dac_mosi)
    );

    assign dac_sclk = step.sclk;

    // one over-current check per axis
    for (genvar i = 0; i < qla_pkg::NUM_AXES; i++) begin : g_safety
        safety_check u_safety (
            .sysclk        (sysclk),
            .rst_n         (rst_n),
            .cur_in        (cur_fb[i]),
            .cmd_in        (cmd[i]),
            .clear_disable (amp_clear[i]),
            .amp_disable   (amp_disable[i])
        );
    end

endmodule

`default_nettype wire

// File: verification/tb_qla_motor.sv
`default_nettype none

module tb_qla_motor;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IDLE_CYCLES    = 16;                       // csel high this long means idle
    localparam int FRAME_BUDGET   = 8;                        // 2 + 4 + 0 + 2 frames over the tests
    localparam int TIMEOUT_CYCLES = FRAME_BUDGET * 300 + 2000;
    localparam int TRIP_AXIS      = 1;

    logic                            sysclk;
    logic                            rst_n;
    logic                            reg_wen;
    qla_pkg::reg_addr_t              reg_waddr;
    qla_pkg::reg_addr_t              reg_raddr;
    qla_pkg::reg_data_t              reg_wdata;
    qla_pkg::reg_data_t              reg_rdata;
    qla_pkg::axis_cur_t              cur_fb;
    logic                            dac_sclk;
    logic                            dac_mosi;
    logic                            dac_csel;
    qla_pkg::axis_mask_t             amp_disable;

    // reference state of the registers
    qla_pkg::cur_t                   exp_cmd [qla_pkg::NUM_AXES];
    qla_pkg::axis_mask_t             exp_amp_en;
    qla_pkg::axis_mask_t             exp_amp_dis;   // latched trips
    logic [31:0]                     rng = 32'h8ddd;

    // frame monitor state
    logic                            sclk_prev = 1'b0;
    logic                            csel_prev = 1'b1;
    int                              bit_cnt = 0;
    int                              high_cnt = qla_pkg::CSEL_GAP;
    int                              frame_cnt = 0;
    logic [qla_pkg::FRAME_BITS-1:0]  cur_frame = '0;
    logic [qla_pkg::FRAME_BITS-1:0]  last_frame = '0;

    int                              value_errs = 0;
    int                              other_errs = 0;
    int                              cycle_cnt = 0;

    qla_motor_top u_dut (
        .sysclk      (sysclk),
        .rst_n       (rst_n),
        .reg_wen     (reg_wen),
        .reg_waddr   (reg_waddr),
        .reg_raddr   (reg_raddr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .cur_fb      (cur_fb),
        .dac_sclk    (dac_sclk),
        .dac_mosi    (dac_mosi),
        .dac_csel    (dac_csel),
        .amp_disable (amp_disable)
    );

    initial begin
        sysclk = 1'b0;
        forever #4 sysclk = ~sysclk;   // 8 ns period
    end

    // ----------------------------------------------------------------------
    // frame monitor samples at the falling sysclk edge where all is stable
    always @(negedge sysclk) begin
        if (rst_n) begin
            if (!dac_csel) begin
                if (csel_prev) begin   // frame start
                    if (high_cnt < qla_pkg::CSEL_GAP) begin
                        other_errs++;
                        $display("chip select was high for only %0d cycles between frames",
                                 high_cnt);
                    end
                    bit_cnt   = 0;
                    cur_frame = '0;
                end
                if (dac_sclk && !sclk_prev) begin   // data valid on the sclk rise
                    cur_frame = {cur_frame[qla_pkg::FRAME_BITS-2:0], dac_mosi};
                    bit_cnt++;
                end
                high_cnt = 0;
            end else begin
                if (!csel_prev) begin   // frame end
                    if (bit_cnt != qla_pkg::FRAME_BITS) begin
                        other_errs++;
                        $display("DAC frame had %0d bits instead of %0d", bit_cnt,
                                 qla_pkg::FRAME_BITS);
                    end
                    last_frame = cur_frame;
                    frame_cnt++;
                end
                high_cnt++;
            end
        end
        sclk_prev = dac_sclk;
        csel_prev = dac_csel;
    end

    // watchdog
    always @(posedge sysclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks failed: %0d value, %0d other", value_errs, other_errs);
            $display("Done: errors found");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // compare tasks
    task automatic check_data(input string name, input qla_pkg::reg_data_t got,
                              input qla_pkg::reg_data_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame(input string name, input logic [qla_pkg::FRAME_BITS-1:0] got,
                               input logic [qla_pkg::FRAME_BITS-1:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input qla_pkg::axis_mask_t got,
                              input qla_pkg::axis_mask_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errs++;
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // ----------------------------------------------------------------------
    // helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic qla_pkg::reg_addr_t reg_addr(input logic [3:0] chan,
                                                    input logic [3:0] off);
        return {qla_pkg::ADDR_MAIN, 4'h0, chan, off};
    endfunction

    // axis 4 in the top word and sent first
    function automatic logic [qla_pkg::FRAME_BITS-1:0] expected_frame();
        logic [qla_pkg::FRAME_BITS-1:0] f;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++)
            f[i*qla_pkg::DAC_BITS +: qla_pkg::DAC_BITS] = exp_cmd[i];
        return f;
    endfunction

    function automatic qla_pkg::reg_data_t status_word(input qla_pkg::axis_mask_t en,
                                                       input qla_pkg::axis_mask_t dis);
        qla_pkg::reg_data_t w;
        w = '0;
        w[3:0]  = en;
        w[11:8] = dis;
        return w;
    endfunction

    task automatic reg_write(input qla_pkg::reg_addr_t addr, input qla_pkg::reg_data_t data);
        @(posedge sysclk);
        reg_wen   <= 1'b1;
        reg_waddr <= addr;
        reg_wdata <= data;
        @(posedge sysclk);   // write edge
        reg_wen   <= 1'b0;
    endtask

    task automatic read_and_check(input string name, input qla_pkg::reg_addr_t addr,
                                  input qla_pkg::reg_data_t exp);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);   // read data is combinational
        check_data(name, reg_rdata, exp);
    endtask

    task automatic write_cmd(input int axis, input qla_pkg::cur_t value);
        reg_write(reg_addr(4'(axis + 1), qla_pkg::OFF_DAC_CTRL), {16'h0, value});
        exp_cmd[axis] = value;
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < qla_pkg::NUM_AXES; i++)
            read_and_check($sformatf("reg_rdata dac%0d", i + 1),
                           reg_addr(4'(i + 1), qla_pkg::OFF_DAC_CTRL), {16'h0, exp_cmd[i]});
        read_and_check("reg_rdata status", reg_addr(qla_pkg::CHAN_BOARD,
                       qla_pkg::OFF_BOARD_STATUS), status_word(exp_amp_en, exp_amp_dis));
    endtask

    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < IDLE_CYCLES) begin
            @(negedge sysclk);
            if (dac_csel)
                quiet++;
            else
                quiet = 0;
        end
    endtask

    // over-current on the masked axes and zero feedback elsewhere
    task automatic set_feedback(input qla_pkg::axis_mask_t over);
        @(posedge sysclk);
        for (int i = 0; i < qla_pkg::NUM_AXES; i++)
            cur_fb[i] <= over[i] ? ((exp_cmd[i] << 1) | 16'h0001) : 16'h0000;
    endtask

    // ----------------------------------------------------------------------
    // tests
    task automatic test_reset();
        @(negedge sysclk);
        check_bit("dac_csel", dac_csel, 1'b1);
        check_bit("dac_sclk", dac_sclk, 1'b0);
        check_bit("dac_mosi", dac_mosi, 1'b0);
        check_mask("amp_disable", amp_disable, '0);
        check_all_regs();
    endtask

    task automatic test_command_frame();
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            rng = xorshift32(rng);
            write_cmd(i, rng[15:0]);
        end
        wait_idle();
        check_frame("dac frame", last_frame, expected_frame());
        check_all_regs();
    endtask

    task automatic test_write_during_frame();
        int frames_before;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            rng = xorshift32(rng);
            write_cmd(i, rng[15:0]);
        end
        wait_idle();
        frames_before = frame_cnt;
        rng = xorshift32(rng);
        write_cmd(0, rng[15:0]);   // one frame starts and clears the pending flag
        while (dac_csel)
            @(negedge sysclk);
        rng = xorshift32(rng);   // these land mid-frame
        write_cmd(1, rng[15:0]);
        rng = xorshift32(rng);
        write_cmd(3, rng[15:0]);
        wait_idle();
        if (frame_cnt - frames_before < 2) begin
            other_errs++;
            $display("write during a frame did not start a further frame");
        end
        check_frame("dac frame", last_frame, expected_frame());
        check_all_regs();
    endtask

    task automatic test_unmapped();
        qla_pkg::reg_addr_t bad [4] = '{16'h1011, 16'h0015, 16'h0051, 16'h0002};
        int                 frames_before;
        frames_before = frame_cnt;
        foreach (bad[i])
            read_and_check($sformatf("reg_rdata @%h", bad[i]), bad[i], '0);
        foreach (bad[i]) begin
            rng = xorshift32(rng);
            reg_write(bad[i], rng);
        end
        wait_idle();
        if (frame_cnt != frames_before) begin
            other_errs++;
            $display("write to an unmapped address started a DAC frame");
        end
        check_all_regs();
    endtask

    task automatic test_safety_trip();
        qla_pkg::axis_mask_t trip;
        trip = '0;
        trip[TRIP_AXIS] = 1'b1;
        for (int i = 0; i < qla_pkg::NUM_AXES; i++) begin
            rng = xorshift32(rng);
            write_cmd(i, rng[15:0] & 16'h0fff);   // keeps 2*cmd+1 in 16 bits
        end
        wait_idle();
        set_feedback(trip);   // short burst of 4 excess cycles
        repeat (3) @(posedge sysclk);
        set_feedback('0);
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        check_mask("amp_disable", amp_disable, '0);
        set_feedback(trip);
        for (int c = 1; c <= 40; c++) begin
            @(posedge sysclk);
            @(negedge sysclk);
            check_mask($sformatf("amp_disable after %0d cycles", c), amp_disable,
                       (c >= qla_pkg::SAFETY_COUNT) ? trip : 4'b0000);
        end
        exp_amp_dis = trip;
        set_feedback('0);
        read_and_check("reg_rdata status", reg_addr(qla_pkg::CHAN_BOARD,
                       qla_pkg::OFF_BOARD_STATUS), status_word(exp_amp_en, exp_amp_dis));
    endtask

    task automatic test_clear();
        qla_pkg::reg_addr_t  status_addr;
        qla_pkg::reg_data_t  d;
        qla_pkg::axis_mask_t pair;
        status_addr = reg_addr(qla_pkg::CHAN_BOARD, qla_pkg::OFF_BOARD_STATUS);
        d = '0;
        d[TRIP_AXIS] = 1'b1;   // single-axis clear
        reg_write(status_addr, d);
        exp_amp_en  = d[3:0];
        exp_amp_dis = '0;
        @(posedge sysclk);
        @(negedge sysclk);
        check_mask("amp_disable", amp_disable, exp_amp_dis);
        read_and_check("reg_rdata status", status_addr, status_word(exp_amp_en, exp_amp_dis));
        pair = 4'b1001;
        set_feedback(pair);
        repeat (qla_pkg::SAFETY_COUNT + 4) @(posedge sysclk);
        set_feedback('0);
        @(negedge sysclk);
        check_mask("amp_disable", amp_disable, pair);
        d = '0;
        d[qla_pkg::PWR_CLEAR_BIT] = 1'b1;   // clears all axes
        d[3:0] = 4'b0110;
        reg_write(status_addr, d);
        exp_amp_en = 4'b0110;
        @(posedge sysclk);
        @(negedge sysclk);
        check_mask("amp_disable", amp_disable, '0);
        read_and_check("reg_rdata status", status_addr, status_word(exp_amp_en, '0));
    endtask

    // ----------------------------------------------------------------------
    initial begin
        rst_n     <= 1'b0;
        reg_wen   <= 1'b0;
        reg_waddr <= '0;
        reg_raddr <= '0;
        reg_wdata <= '0;
        cur_fb    <= '0;
        exp_amp_en  = '0;
        exp_amp_dis = '0;
        foreach (exp_cmd[i])
            exp_cmd[i] = '0;
        repeat (10) @(posedge sysclk);
        rst_n <= 1'b1;

        test_reset();
        test_command_frame();
        test_write_during_frame();
        test_unmapped();
        test_safety_trip();
        test_clear();

        $display("checks failed: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
common/qla_pkg.sv
common/dac_step_if.sv
src/board_regs.sv
src/safety_check.sv
dac/dac_seq_fsm.sv
dac/spi_bit_timer.sv
dac/dac_shifter.sv
src/qla_motor_top.sv
verification/tb_qla_motor.sv

// File: Makefile
# Verilator build and run for the motor register path

VERILATOR ?= verilator
TOP       ?= tb_qla_motor
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
